/* filelist.f */
+incdir+source
source/cache_pkg.sv
source/line_store.sv
source/lru_tracker.sv
source/cache_controller.sv
source/main_memory.sv
source/cache_top.sv
verif/cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it, judge the log
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module cache_tb \
    -o cache_sim

./obj_dir/cache_sim | tee "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

/* verif/cache_tb.sv */
// ##########################################################
// directed testbench for the cache with a word-level model
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_tb;

    localparam int SETS         = `CACHE_SETS;
    localparam int ASSOC        = `CACHE_ASSOC;
    localparam int HIT_CYCLES   = 2;
    localparam int MISS_CYCLES  = 2 + `MEM_LATENCY + 1;
    localparam int DIRTY_CYCLES = MISS_CYCLES + `MEM_LATENCY + 1;
    localparam int WAIT_LIMIT   = 100;
    localparam int RANDOM_OPS   = 300;
    localparam logic [31:0] RANDOM_SEED = 32'h530f_95b2;

    logic        clock;
    logic        reset;
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [3:0]  byte_mask;
    logic [31:0] write_word;
    logic        busy;
    logic        done;
    logic        hit;
    logic [31:0] read_word;

    // reference model: memory words plus per-set tags and LRU ranks
    logic [31:0]                model_mem [`MEM_WORDS];
    logic [`CACHE_TAG_BITS-1:0] model_tag [SETS][ASSOC];
    logic                       model_valid [SETS][ASSOC];
    int                         model_rank [SETS][ASSOC];

    string       test_name;
    int          test_errors;
    int          total_errors;
    int          total_checks;
    int          tests_run;
    int          tests_failed;
    int          last_cycles;
    logic        last_hit;
    logic [31:0] last_word;

    cache_top dut (
        .clock, .reset,
        .req, .we, .addr, .byte_mask, .write_word,
        .busy, .done, .hit, .read_word
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] build_addr(input int tag, input int set, input int word);
        return (32'(tag) << (2 + `CACHE_OFFSET_BITS + `CACHE_INDEX_BITS))
             | (32'(set) << (2 + `CACHE_OFFSET_BITS))
             | (32'(word) << 2);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] mask);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // tag lookup, LRU victim on a miss, then move the used way to rank 0
    task automatic predict_access(input logic [31:0] a, output logic predicted_hit);
        int set;
        int way;
        int old_rank;
        set = int'(a[6:4]);
        way = -1;
        for (int w = 0; w < ASSOC; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == a[31:7]) begin
                way = w;
            end
        end
        predicted_hit = (way >= 0);
        if (way < 0) begin
            for (int w = 0; w < ASSOC; w++) begin
                if (model_rank[set][w] == ASSOC - 1) begin
                    way = w;
                end
            end
            model_valid[set][way] = 1'b1;
            model_tag[set][way]   = a[31:7];
        end
        old_rank = model_rank[set][way];
        for (int w = 0; w < ASSOC; w++) begin
            if (w == way) begin
                model_rank[set][w] = 0;
            end else if (model_rank[set][w] < old_rank) begin
                model_rank[set][w] = model_rank[set][w] + 1;
            end
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        total_checks++;
        assert (expected === actual) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic open_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic close_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    // one request, started on a falling edge, checked against the model
    task automatic issue_access(input logic write, input logic [31:0] a,
                                input logic [3:0] mask, input logic [31:0] data);
        logic        exp_hit;
        logic [31:0] exp_word;
        int          cycles;
        predict_access(a, exp_hit);
        exp_word = model_mem[a[13:2]];
        if (write) begin
            exp_word = merge_bytes(exp_word, data, mask);
            model_mem[a[13:2]] = exp_word;
        end
        req        = 1'b1;
        we         = write;
        addr       = a;
        byte_mask  = mask;
        write_word = data;
        @(negedge clock);
        req    = 1'b0;
        cycles = 1;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!done) begin
            $display("timeout: no done within %0d cycles in test %s", WAIT_LIMIT, test_name);
            $display("RESULT: FAIL");
            $finish;
        end else begin
            last_cycles = cycles;
            last_hit    = hit;
            last_word   = read_word;
            check_value("hit", 32'(exp_hit), 32'(hit));
            check_value("read_word", exp_word, read_word);
            check_value("busy at done", 32'h0, 32'(busy));
        end
    endtask

    task automatic cold_read_then_hit();
        open_test("cold_read");
        issue_access(1'b0, build_addr(2, 2, 1), 4'hf, 32'h0);
        check_value("cold hit", 32'h0, 32'(last_hit));
        check_value("cold data", 32'h0, last_word);
        issue_access(1'b0, build_addr(2, 2, 1), 4'hf, 32'h0);
        check_value("re-read hit", 32'h1, 32'(last_hit));
        close_test();
    endtask

    task automatic merge_masked_bytes();
        logic [31:0] a;
        open_test("byte_merge");
        a = build_addr(4, 0, 3);
        issue_access(1'b1, a, 4'b0001, 32'h1122_3344);
        issue_access(1'b0, a, 4'hf, 32'h0);
        issue_access(1'b1, a, 4'b0110, 32'haabb_ccdd);
        issue_access(1'b0, a, 4'hf, 32'h0);
        issue_access(1'b1, a, 4'b1111, 32'h5566_7788);
        issue_access(1'b0, a, 4'hf, 32'h0);
        issue_access(1'b1, a, 4'b0000, 32'hffff_ffff);
        issue_access(1'b0, a, 4'hf, 32'h0);
        close_test();
    endtask

    task automatic evict_dirty_line();
        open_test("eviction");
        for (int t = 1; t <= 5; t++) begin
            issue_access(1'b1, build_addr(t, 5, 1), 4'hf, 32'hd00d_0000 + 32'(t));
        end
        // the fifth tag pushes out a dirty line before its refill
        check_value("write-back cycles", 32'(DIRTY_CYCLES), 32'(last_cycles));
        issue_access(1'b0, build_addr(1, 5, 1), 4'hf, 32'h0);
        check_value("evicted tag hit", 32'h0, 32'(last_hit));
        check_value("evicted tag data", 32'hd00d_0001, last_word);
        close_test();
    endtask

    task automatic follow_lru_order();
        open_test("lru_order");
        for (int t = 0; t < 4; t++) begin
            issue_access(1'b0, build_addr(20 + t, 6, 0), 4'hf, 32'h0);
        end
        issue_access(1'b0, build_addr(20, 6, 0), 4'hf, 32'h0);
        issue_access(1'b0, build_addr(24, 6, 0), 4'hf, 32'h0);
        issue_access(1'b0, build_addr(20, 6, 0), 4'hf, 32'h0);
        check_value("tag 0 hit", 32'h1, 32'(last_hit));
        issue_access(1'b0, build_addr(22, 6, 0), 4'hf, 32'h0);
        check_value("tag 2 hit", 32'h1, 32'(last_hit));
        issue_access(1'b0, build_addr(23, 6, 0), 4'hf, 32'h0);
        check_value("tag 3 hit", 32'h1, 32'(last_hit));
        issue_access(1'b0, build_addr(21, 6, 0), 4'hf, 32'h0);
        check_value("tag 1 hit", 32'h0, 32'(last_hit));
        close_test();
    endtask

    task automatic measure_timing();
        logic [31:0] a;
        logic        predicted;
        int          done_count;
        open_test("timing");
        a = build_addr(9, 7, 2);
        issue_access(1'b0, a, 4'hf, 32'h0);
        check_value("clean miss cycles", 32'(MISS_CYCLES), 32'(last_cycles));
        issue_access(1'b0, a, 4'hf, 32'h0);
        check_value("hit cycles", 32'(HIT_CYCLES), 32'(last_cycles));
        // a second req during the miss must be dropped
        a = build_addr(10, 7, 0);
        predict_access(a, predicted);
        req        = 1'b1;
        we         = 1'b0;
        addr       = a;
        byte_mask  = 4'hf;
        write_word = 32'h0;
        @(negedge clock);
        check_value("busy after req", 32'h1, 32'(busy));
        addr = build_addr(11, 7, 0);
        @(negedge clock);
        req        = 1'b0;
        done_count = 0;
        for (int c = 0; c < 4 * MISS_CYCLES; c++) begin
            if (done) begin
                done_count++;
                check_value("accepted req hit", 32'(predicted), 32'(hit));
                check_value("accepted req data", model_mem[a[13:2]], read_word);
            end
            @(negedge clock);
        end
        check_value("done count", 32'h1, 32'(done_count));
        close_test();
    endtask

    task automatic run_random_mix();
        logic [5:0] w;
        open_test("random_mix");
        for (int i = 0; i < RANDOM_OPS; i++) begin
            w = 6'($urandom_range(63, 0));
            // 8 tags over 4 sets, so lines get evicted and written back
            issue_access(1'($urandom_range(1, 0)),
                         build_addr(int'(w[5:3]), int'(w[2:1]), int'(w[0])),
                         4'($urandom_range(15, 0)), $urandom);
        end
        close_test();
    endtask

    initial begin
        req          = 1'b0;
        we           = 1'b0;
        addr         = 32'h0;
        byte_mask    = 4'h0;
        write_word   = 32'h0;
        reset        = 1'b0;
        total_errors = 0;
        total_checks = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(RANDOM_SEED));
        for (int i = 0; i < `MEM_WORDS; i++) begin
            model_mem[i] = 32'h0;
        end
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < ASSOC; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
                model_rank[s][w]  = w;
            end
        end
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        cold_read_then_hit();
        merge_masked_bytes();
        evict_dirty_line();
        follow_lru_order();
        measure_timing();
        run_random_mix();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/cache_top.sv */
// ##########################################################
// cache subsystem: controller, stores, LRU and memory
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_top (
    input  logic        clock,
    input  logic        reset,
    input  logic        req,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [3:0]  byte_mask,
    input  logic [31:0] write_word,
    output logic        busy,
    output logic        done,
    output logic        hit,
    output logic [31:0] read_word
);

    cache_pkg::set_index_t                     tag_set;
    cache_pkg::tag_entry_t [`CACHE_ASSOC-1:0]  tag_ways;
    logic                                      tag_write;
    cache_pkg::way_index_t                     tag_write_way;
    cache_pkg::tag_entry_t                     tag_write_entry;
    cache_pkg::data_block_t [`CACHE_ASSOC-1:0] data_ways;
    logic                                      data_write;
    cache_pkg::way_index_t                     data_write_way;
    cache_pkg::data_block_t                    data_write_block;
    cache_pkg::way_index_t                     victim;
    logic                                      touch;
    cache_pkg::way_index_t                     touch_way;
    logic                                      mem_read;
    logic                                      mem_write;
    logic [31:0]                               mem_addr;
    cache_pkg::data_block_t                    mem_write_block;
    cache_pkg::data_block_t                    mem_read_block;
    logic                                      mem_ready;

    cache_controller u_controller (
        .clock, .reset,
        .req, .we, .addr, .byte_mask, .write_word,
        .busy, .done, .hit, .read_word,
        .tag_set, .tag_ways, .tag_write, .tag_write_way, .tag_write_entry,
        .data_ways, .data_write, .data_write_way, .data_write_block,
        .victim, .touch, .touch_way,
        .mem_read, .mem_write, .mem_addr, .mem_write_block,
        .mem_read_block, .mem_ready
    );

    // tags and data indexed by the same set
    line_store #(
        .entry_t     (cache_pkg::tag_entry_t),
        .RESET_VALUE (cache_pkg::tag_entry_t'('0))
    ) tag_store (
        .clock, .reset,
        .set          (tag_set),
        .ways         (tag_ways),
        .write_enable (tag_write),
        .write_way    (tag_write_way),
        .write_entry  (tag_write_entry)
    );

    line_store #(
        .entry_t     (cache_pkg::data_block_t),
        .RESET_VALUE (cache_pkg::data_block_t'('0))
    ) data_store (
        .clock, .reset,
        .set          (tag_set),
        .ways         (data_ways),
        .write_enable (data_write),
        .write_way    (data_write_way),
        .write_entry  (data_write_block)
    );

    lru_tracker u_lru (
        .clock, .reset,
        .set       (tag_set),
        .victim    (victim),
        .touch     (touch),
        .touch_way (touch_way)
    );

    main_memory u_memory (
        .clock,
        .mem_read, .mem_write, .mem_addr, .mem_write_block,
        .mem_read_block, .mem_ready
    );

endmodule

`default_nettype wire

/* source/main_memory.sv */
// ##########################################################
// behavioral block-wide memory with fixed latency
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module main_memory (
    input  logic                   clock,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  logic [31:0]            mem_addr,
    input  cache_pkg::data_block_t mem_write_block,
    output cache_pkg::data_block_t mem_read_block,
    output logic                   mem_ready
);

    localparam int BLOCK_BITS = $clog2(`MEM_BLOCKS);
    localparam int CNT_BITS   = $clog2(`MEM_LATENCY + 1);

    // zero at time zero, reset never touches the contents
    cache_pkg::data_block_t blocks [`MEM_BLOCKS] = '{default: '0};

    logic                   pending = 1'b0;
    logic [CNT_BITS-1:0]    count = '0;
    logic                   is_write = 1'b0;
    logic [BLOCK_BITS-1:0]  index_q = '0;
    cache_pkg::data_block_t wdata_q = '0;

    // block address, word offset and byte bits dropped
    logic [BLOCK_BITS-1:0]  index;

    assign index = mem_addr[`CACHE_OFFSET_BITS+2 +: BLOCK_BITS];

    // ready exactly MEM_LATENCY cycles after the strobe cycle
    assign mem_ready      = pending && (count == '0);
    assign mem_read_block = blocks[index_q];

    always_ff @(posedge clock) begin
        if (pending) begin
            if (count == '0) begin
                pending <= 1'b0;
                // write is committed as it completes
                if (is_write) begin
                    blocks[index_q] <= wdata_q;
                end
            end else begin
                count <= count - 1'b1;
            end
        end else if (mem_read || mem_write) begin
            pending  <= 1'b1;
            count    <= CNT_BITS'(`MEM_LATENCY - 1);
            is_write <= mem_write;
            index_q  <= index;
            wdata_q  <= mem_write_block;
        end
    end

endmodule

`default_nettype wire

/* source/cache_controller.sv */
// ##########################################################
// cache FSM: lookup, hit merge, write-back, refill, done
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_controller (
    input  logic                                      clock,
    input  logic                                      reset,
    // cpu side
    input  logic                                      req,
    input  logic                                      we,
    input  logic [31:0]                               addr,
    input  logic [3:0]                                byte_mask,
    input  logic [31:0]                               write_word,
    output logic                                      busy,
    output logic                                      done,
    output logic                                      hit,
    output logic [31:0]                               read_word,
    // tag and data stores share the set
    output cache_pkg::set_index_t                     tag_set,
    input  cache_pkg::tag_entry_t [`CACHE_ASSOC-1:0]  tag_ways,
    output logic                                      tag_write,
    output cache_pkg::way_index_t                     tag_write_way,
    output cache_pkg::tag_entry_t                     tag_write_entry,
    input  cache_pkg::data_block_t [`CACHE_ASSOC-1:0] data_ways,
    output logic                                      data_write,
    output cache_pkg::way_index_t                     data_write_way,
    output cache_pkg::data_block_t                    data_write_block,
    // lru
    input  cache_pkg::way_index_t                     victim,
    output logic                                      touch,
    output cache_pkg::way_index_t                     touch_way,
    // memory
    output logic                                      mem_read,
    output logic                                      mem_write,
    output logic [31:0]                               mem_addr,
    output cache_pkg::data_block_t                    mem_write_block,
    input  cache_pkg::data_block_t                    mem_read_block,
    input  logic                                      mem_ready
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_wb_wait,
        st_refill_wait,
        st_finish
    } state_t;

    state_t                  state;
    cache_pkg::tag_t         tag_q;
    cache_pkg::set_index_t   set_q;
    cache_pkg::word_offset_t off_q;
    logic                    we_q;
    logic [3:0]              mask_q;
    logic [31:0]             wword_q;
    cache_pkg::way_index_t   victim_q;
    logic                    hit_q;
    logic [31:0]             read_word_q;

    logic                    hit_any;
    cache_pkg::way_index_t   hit_way;
    cache_pkg::way_index_t   fill_way;
    cache_pkg::tag_entry_t   victim_entry;
    cache_pkg::data_block_t  base_block;
    cache_pkg::data_block_t  new_block;
    logic [31:0]             new_word;
    logic                    do_hit;
    logic                    do_fill;
    logic                    accept;

    assign busy      = state inside {st_lookup, st_wb_wait, st_refill_wait};
    assign done      = (state == st_finish);
    assign hit       = hit_q;
    assign read_word = read_word_q;
    assign accept    = req && !busy;
    assign tag_set   = set_q;

    // tag compare across all ways of the latched set
    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_ASSOC; w++) begin
            if (tag_ways[w].valid && tag_ways[w].tag == tag_q) begin
                hit_any = 1'b1;
                hit_way = cache_pkg::way_index_t'(w);
            end
        end
    end

    assign victim_entry = tag_ways[victim];
    assign do_hit       = (state == st_lookup) && hit_any;
    assign do_fill      = (state == st_refill_wait) && mem_ready;
    assign fill_way     = (state == st_refill_wait) ? victim_q : hit_way;

    // byte merge on top of the cached or refilled block
    always_comb begin
        base_block = (state == st_refill_wait) ? mem_read_block : data_ways[hit_way];
        new_word   = base_block[off_q];
        if (we_q) begin
            for (int b = 0; b < 4; b++) begin
                if (mask_q[b]) begin
                    new_word[8*b +: 8] = wword_q[8*b +: 8];
                end
            end
        end
        new_block        = base_block;
        new_block[off_q] = new_word;
    end

    // a read hit leaves the stores alone and only touches the LRU
    assign data_write       = do_fill || (do_hit && we_q);
    assign data_write_way   = fill_way;
    assign data_write_block = new_block;
    assign tag_write        = data_write;
    assign tag_write_way    = fill_way;
    assign tag_write_entry  = '{valid: 1'b1, dirty: we_q, tag: tag_q};
    assign touch            = do_hit || do_fill;
    assign touch_way        = fill_way;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state     <= st_idle;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            hit_q     <= 1'b0;
        end else begin
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            case (state)
                st_idle, st_finish: begin
                    state <= accept ? st_lookup : st_idle;
                end
                st_lookup: begin
                    hit_q <= hit_any;
                    if (hit_any) begin
                        state <= st_finish;
                    end else if (victim_entry.valid && victim_entry.dirty) begin
                        mem_write <= 1'b1;
                        state     <= st_wb_wait;
                    end else begin
                        mem_read <= 1'b1;
                        state    <= st_refill_wait;
                    end
                end
                st_wb_wait: begin
                    if (mem_ready) begin
                        mem_read <= 1'b1;
                        state    <= st_refill_wait;
                    end
                end
                st_refill_wait: begin
                    if (mem_ready) begin
                        state <= st_finish;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request, memory payload and result registers
    always_ff @(posedge clock) begin
        if (accept) begin
            tag_q   <= addr[31 -: `CACHE_TAG_BITS];
            set_q   <= addr[`CACHE_OFFSET_BITS+2 +: `CACHE_INDEX_BITS];
            off_q   <= addr[2 +: `CACHE_OFFSET_BITS];
            we_q    <= we;
            mask_q  <= byte_mask;
            wword_q <= write_word;
        end
        if (state == st_lookup && !hit_any) begin
            victim_q        <= victim;
            mem_write_block <= data_ways[victim];
            if (victim_entry.valid && victim_entry.dirty) begin
                mem_addr <= {victim_entry.tag, set_q, {(`CACHE_OFFSET_BITS+2){1'b0}}};
            end else begin
                mem_addr <= {tag_q, set_q, {(`CACHE_OFFSET_BITS+2){1'b0}}};
            end
        end
        // write-back done, point the refill at the requested block
        if (state == st_wb_wait && mem_ready) begin
            mem_addr <= {tag_q, set_q, {(`CACHE_OFFSET_BITS+2){1'b0}}};
        end
        if (do_hit || do_fill) begin
            read_word_q <= new_word;
        end
    end

endmodule

`default_nettype wire

/* source/lru_tracker.sv */
// ##########################################################
// exact LRU ranks per set, victim pick and rank update
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module lru_tracker (
    input  logic                  clock,
    input  logic                  reset,
    input  cache_pkg::set_index_t set,
    output cache_pkg::way_index_t victim,
    input  logic                  touch,
    input  cache_pkg::way_index_t touch_way
);

    // rank 0 is most recent, ASSOC-1 is the victim
    cache_pkg::way_index_t [`CACHE_ASSOC-1:0] ranks [`CACHE_SETS];

    cache_pkg::way_index_t touched_rank;

    assign touched_rank = ranks[set][touch_way];

    // ranks in a set are a permutation, so exactly one way matches
    always_comb begin
        victim = '0;
        for (int w = 0; w < `CACHE_ASSOC; w++) begin
            if (ranks[set][w] == cache_pkg::way_index_t'(`CACHE_ASSOC - 1)) begin
                victim = cache_pkg::way_index_t'(w);
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            // way n starts at rank n
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_ASSOC; w++) begin
                    ranks[s][w] <= cache_pkg::way_index_t'(w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < `CACHE_ASSOC; w++) begin
                if (cache_pkg::way_index_t'(w) == touch_way) begin
                    ranks[set][w] <= '0;
                end else if (ranks[set][w] < touched_rank) begin
                    // more recent than the touched way, age by one
                    ranks[set][w] <= ranks[set][w] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/line_store.sv */
// ##########################################################
// set-by-way entry array, all ways of a set read at once
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module line_store #(
    parameter type entry_t = logic [31:0],
    parameter entry_t RESET_VALUE = '0
) (
    input  logic                   clock,
    input  logic                   reset,
    input  cache_pkg::set_index_t  set,
    output entry_t [`CACHE_ASSOC-1:0] ways,
    input  logic                   write_enable,
    input  cache_pkg::way_index_t  write_way,
    input  entry_t                 write_entry
);

    entry_t [`CACHE_ASSOC-1:0] entries [`CACHE_SETS];

    // combinational read of the whole set
    assign ways = entries[set];

    // write lands in the set currently addressed
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_ASSOC; w++) begin
                    entries[s][w] <= RESET_VALUE;
                end
            end
        end else if (write_enable) begin
            entries[set][write_way] <= write_entry;
        end
    end

endmodule

`default_nettype wire

/* source/cache_pkg.sv */
// ##########################################################
// cache types: tag entries, data blocks, address fields
// ##########################################################

`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

    // address fields
    typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] set_index_t;
    typedef logic [`CACHE_OFFSET_BITS-1:0] word_offset_t;

    // way number, also used as an LRU rank
    typedef logic [`CACHE_LRU_BITS-1:0] way_index_t;

    // one tag entry per way
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // a full block, word 0 in the low bits
    typedef logic [`CACHE_BLOCK_WORDS-1:0][31:0] data_block_t;

endpackage

`default_nettype wire

/* source/cache_defines.svh */
// ##########################################################
// cache geometry, memory size and memory latency
// ##########################################################

`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// address split: tag | set | word offset | byte
`define CACHE_TAG_BITS 25
`define CACHE_INDEX_BITS 3
`define CACHE_OFFSET_BITS 2

// ways per set, and the rank width for the LRU order
`define CACHE_ASSOC 4
`define CACHE_LRU_BITS ($clog2(`CACHE_ASSOC))

// derived cache sizes
`define CACHE_SETS (1 << `CACHE_INDEX_BITS)
`define CACHE_BLOCK_WORDS (1 << `CACHE_OFFSET_BITS)

// backing memory depth in 32-bit words
`define MEM_WORDS 4096

// same memory counted in cache blocks
`define MEM_BLOCKS (`MEM_WORDS / `CACHE_BLOCK_WORDS)

// cycles from a read or write strobe to mem_ready
`define MEM_LATENCY 4

`endif
